/* fetchPkg.sv */
package fetchPkg;

    // text segment bounds, end is the first address past the segment
    localparam logic [31:0] textStart = 32'h0000_3000;
    localparam logic [31:0] textEnd = 32'h0000_3080;

    // kernel entry vector
    localparam logic [31:0] kTextStart = 32'h0000_3060;

    // instruction memory depth in words
    localparam int memWords = 32;

    // word index width, taken from address bits 6 to 2
    localparam int memIdxW = $clog2(memWords);

    // exception code field
    localparam int excW = 5;
    localparam logic [excW-1:0] excAdEl = 5'd4;

    // control flow kind of the instruction in decode
    typedef enum logic [1:0] {
        seq     = 2'd0,
        branch  = 2'd1,
        jumpImm = 2'd2,
        jumpReg = 2'd3
    } jumpKind_t;

    // kernel control request from coprocessor 0
    typedef enum logic [1:0] {
        kNone  = 2'd0,
        kEnter = 2'd1,
        kEret  = 2'd2
    } kCtrl_t;

endpackage

/* fetchStage.sv */
module fetchStage import fetchPkg::*; (
    input  logic            clk,
    input  logic            reset,
    input  logic            stall,
    input  logic            clr,
    input  jumpKind_t       jumpKind,
    input  logic            cmp,
    input  logic [15:0]     imm16,
    input  logic [25:0]     jmpAddr,
    input  logic [31:0]     jmpReg,
    input  kCtrl_t          kCtrl,
    input  logic [31:2]     epc,
    output logic [31:0]     codeId,
    output logic [31:0]     pcId,
    output logic [excW-1:0] excId,
    output logic            bdId,
    output logic            validId,
    output logic [31:0]     pcIf,
    output logic            bdIf
);

    logic [31:0]     npc;
    logic [excW-1:0] exc;

    // wishbone read bus
    logic            wbCyc;
    logic            wbStb;
    logic [31:0]     wbAdr;
    logic            wbAck;
    logic [31:0]     wbDatRd;

    nextPcUnit i_nextPcUnit (
        .pc       (pcIf),
        .jumpKind (jumpKind),
        .cmp      (cmp),
        .imm16    (imm16),
        .jmpAddr  (jmpAddr),
        .jmpReg   (jmpReg),
        .kCtrl    (kCtrl),
        .epc      (epc),
        .npc      (npc),
        .isJump   (bdIf)
    );

    pcUnit i_pcUnit (
        .clk   (clk),
        .reset (reset),
        .stall (stall),
        .npc   (npc),
        .wbAck (wbAck),
        .pc    (pcIf),
        .exc   (exc),
        .wbCyc (wbCyc),
        .wbStb (wbStb),
        .wbAdr (wbAdr)
    );

    instrMem i_instrMem (
        .clk     (clk),
        .reset   (reset),
        .wbCyc   (wbCyc),
        .wbStb   (wbStb),
        .wbAdr   (wbAdr),
        .wbAck   (wbAck),
        .wbDatRd (wbDatRd)
    );

    // ack edge loads the record and advances the PC together
    ifIdReg i_ifIdReg (
        .clk     (clk),
        .reset   (reset),
        .clr     (clr),
        .load    (wbAck),
        .code    (wbDatRd),
        .pc      (pcIf),
        .exc     (exc),
        .bd      (bdIf),
        .codeId  (codeId),
        .pcId    (pcId),
        .excId   (excId),
        .bdId    (bdId),
        .validId (validId)
    );

endmodule

/* fetchStageTb.sv */
module fetchStageTb import fetchPkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    typedef struct packed {
        logic [7:0]  testNum;
        jumpKind_t   jk;
        logic        cmp;
        logic        randImm;
        logic [15:0] imm16;
        logic [25:0] jmpAddr;
        logic [31:0] jmpReg;
        kCtrl_t      kc;
        logic [29:0] epc;
        logic        stall;
        logic        clr;
        logic [4:0]  expExc;
    } row_t;

    localparam int maxRows = 40;
    localparam int timeoutCycles = 10;

    logic        clk;
    logic        reset;
    logic        stall;
    logic        clr;
    jumpKind_t   jumpKind;
    logic        cmp;
    logic [15:0] imm16;
    logic [25:0] jmpAddr;
    logic [31:0] jmpReg;
    kCtrl_t      kCtrl;
    logic [31:2] epc;
    logic [31:0] codeId;
    logic [31:0] pcId;
    logic [4:0]  excId;
    logic        bdId;
    logic        validId;
    logic [31:0] pcIf;
    logic        bdIf;

    row_t        rows [0:maxRows-1];
    int          numRows;
    int          curTest;
    int          testErrors;
    int          testsOk;
    int          testsBad;
    logic [31:0] lcgState;
    logic [31:0] modelPc;
    bit          timedOut;

    fetchStage i_fetchStage (
        .clk (clk), .reset (reset), .stall (stall), .clr (clr),
        .jumpKind (jumpKind), .cmp (cmp), .imm16 (imm16), .jmpAddr (jmpAddr),
        .jmpReg (jmpReg), .kCtrl (kCtrl), .epc (epc),
        .codeId (codeId), .pcId (pcId), .excId (excId), .bdId (bdId),
        .validId (validId), .pcIf (pcIf), .bdIf (bdIf)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic addRow(input int t, input jumpKind_t jk, input logic c, input logic ri,
                          input logic [15:0] imm, input logic [25:0] ja, input logic [31:0] jr,
                          input kCtrl_t kc, input logic [29:0] e, input logic st,
                          input logic cl, input logic [4:0] ex);
        rows[numRows] = {t[7:0], jk, c, ri, imm, ja, jr, kc, e, st, cl, ex};
        numRows++;
    endtask

    task automatic checkField(input string name, input logic [31:0] expVal,
                              input logic [31:0] actVal);
        if (actVal !== expVal) begin
            $display("[FAIL] test %0d %s expected %h got %h", curTest, name, expVal, actVal);
            testErrors++;
        end
    endtask

    // waits on falling edges for the IF/ID slot to hold the given PC
    task automatic waitLoad(input logic [31:0] expPc, input int minCycles, output bit ok);
        int cycles;
        cycles = 0;
        ok = 1'b0;
        while (!ok && cycles < timeoutCycles) begin
            @(negedge clk);
            cycles++;
            if (cycles >= minCycles && validId && pcId == expPc) begin
                ok = 1'b1;
            end
        end
    endtask

    function automatic logic [31:0] nextRandom();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState;
    endfunction

    // word offset to a random target among the first 20 words of the segment
    function automatic logic [15:0] randomOffset(input logic [31:0] pc);
        logic [31:0] target;
        logic [31:0] diff;
        target = textStart + 32'(((nextRandom() >> 16) % 20) * 4);
        diff = target - pc;
        return diff[17:2];
    endfunction

    function automatic logic [31:0] expectedCode(input logic [31:0] pc);
        return 32'hA500_0000 + {25'd0, pc[6:2], 2'b00};
    endfunction

    function automatic logic [31:0] modelNpc(input logic [31:0] pc, input row_t row,
                                             input logic [15:0] imm);
        if (row.kc == kEnter) return kTextStart;
        if (row.kc == kEret) return {row.epc, 2'b00};
        if (pc == kTextStart - 32'd4) return pc;
        if (row.jk == branch && row.cmp) return pc + {{14{imm[15]}}, imm, 2'b00};
        if (row.jk == jumpImm) return {pc[31:28], row.jmpAddr, 2'b00};
        if (row.jk == jumpReg) return row.jmpReg;
        return pc + 32'd4;
    endfunction

    task automatic buildTable();
        // sequential start
        repeat (4) addRow(1, seq, 0, 0, 16'h0, 26'h0, 32'h0, kNone, 30'h0, 0, 0, 5'd0);
        // branches with random offsets
        addRow(2, branch, 1, 1, 16'h0, 26'h0, 32'h0, kNone, 30'h0, 0, 0, 5'd0);
        addRow(2, seq, 0, 0, 16'h0, 26'h0, 32'h0, kNone, 30'h0, 0, 0, 5'd0);
        addRow(2, branch, 0, 1, 16'h0, 26'h0, 32'h0, kNone, 30'h0, 0, 0, 5'd0);
        addRow(2, branch, 1, 1, 16'h0, 26'h0, 32'h0, kNone, 30'h0, 0, 0, 5'd0);
        addRow(2, seq, 0, 0, 16'h0, 26'h0, 32'h0, kNone, 30'h0, 0, 0, 5'd0);
        // jumps, then misaligned and out-of-segment targets
        addRow(3, jumpImm, 0, 0, 16'h0, 26'h0C10, 32'h0, kNone, 30'h0, 0, 0, 5'd0);
        addRow(3, branch, 1, 0, 16'h0002, 26'h0, 32'h0, kNone, 30'h0, 0, 0, 5'd0);
        addRow(3, jumpReg, 0, 0, 16'h0, 26'h0, 32'h3008, kNone, 30'h0, 0, 0, 5'd0);
        addRow(3, jumpReg, 0, 0, 16'h0, 26'h0, 32'h3012, kNone, 30'h0, 0, 0, 5'd0);
        addRow(3, jumpReg, 0, 0, 16'h0, 26'h0, 32'h3020, kNone, 30'h0, 0, 0, excAdEl);
        addRow(3, jumpReg, 0, 0, 16'h0, 26'h0, 32'h4000, kNone, 30'h0, 0, 0, 5'd0);
        addRow(3, jumpReg, 0, 0, 16'h0, 26'h0, 32'h2FFC, kNone, 30'h0, 0, 0, excAdEl);
        addRow(3, jumpReg, 0, 0, 16'h0, 26'h0, 32'h3030, kNone, 30'h0, 0, 0, excAdEl);
        addRow(3, seq, 0, 0, 16'h0, 26'h0, 32'h0, kNone, 30'h0, 0, 0, 5'd0);
        // kernel entry, return and end-of-program hold
        addRow(4, seq, 0, 0, 16'h0, 26'h0, 32'h0, kEnter, 30'h0, 0, 0, 5'd0);
        addRow(4, seq, 0, 0, 16'h0, 26'h0, 32'h0, kNone, 30'h0, 0, 0, 5'd0);
        addRow(4, seq, 0, 0, 16'h0, 26'h0, 32'h0, kEret, 30'hC15, 0, 0, 5'd0);
        repeat (4) addRow(4, seq, 0, 0, 16'h0, 26'h0, 32'h0, kNone, 30'h0, 0, 0, 5'd0);
        addRow(4, jumpReg, 0, 0, 16'h0, 26'h0, 32'h3000, kNone, 30'h0, 0, 0, 5'd0);
        addRow(4, seq, 0, 0, 16'h0, 26'h0, 32'h0, kEret, 30'hC00, 0, 0, 5'd0);
        // stall, then clr
        addRow(5, seq, 0, 0, 16'h0, 26'h0, 32'h0, kNone, 30'h0, 1, 0, 5'd0);
        addRow(5, seq, 0, 0, 16'h0, 26'h0, 32'h0, kNone, 30'h0, 0, 0, 5'd0);
        addRow(5, seq, 0, 0, 16'h0, 26'h0, 32'h0, kNone, 30'h0, 0, 1, 5'd0);
        addRow(5, seq, 0, 0, 16'h0, 26'h0, 32'h0, kNone, 30'h0, 0, 0, 5'd0);
    endtask

    initial begin
        row_t        row;
        logic [31:0] expPc;
        logic [15:0] stimImm;
        int          minCycles;
        bit          ok;
        reset = 1'b1;
        stall = 1'b0;
        clr = 1'b0;
        jumpKind = seq;
        cmp = 1'b0;
        imm16 = '0;
        jmpAddr = '0;
        jmpReg = '0;
        kCtrl = kNone;
        epc = '0;
        numRows = 0;
        testErrors = 0;
        testsOk = 0;
        testsBad = 0;
        lcgState = 32'd34344;
        modelPc = textStart;
        timedOut = 1'b0;
        buildTable();
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        curTest = 1;
        checkField("validId", 32'd0, validId);
        checkField("pcId", 32'd0, pcId);
        for (int r = 0; r < numRows; r++) begin
            row = rows[r];
            curTest = row.testNum;
            expPc = modelPc;
            checkField("pcIf", expPc, pcIf);
            stimImm = row.randImm ? randomOffset(expPc) : row.imm16;
            jumpKind = row.jk;
            cmp = row.cmp;
            imm16 = stimImm;
            jmpAddr = row.jmpAddr;
            jmpReg = row.jmpReg;
            kCtrl = row.kc;
            epc = row.epc;
            stall = row.stall;
            clr = row.clr;
            minCycles = 2;
            if (row.clr) begin
                @(negedge clk);
                checkField("codeId", 32'd0, codeId);
                checkField("pcId", 32'd0, pcId);
                checkField("validId", 32'd0, validId);
                clr = 1'b0;
                minCycles = 1;
            end
            waitLoad(expPc, minCycles, ok);
            if (!ok) begin
                $display("timeout: pc %h not fetched within %0d cycles in test %0d",
                         expPc, timeoutCycles, curTest);
                testsBad++;
                timedOut = 1'b1;
                break;
            end
            checkField("codeId", expectedCode(expPc), codeId);
            checkField("excId", row.expExc, excId);
            checkField("bdId", row.jk != seq, bdId);
            checkField("bdIf", row.jk != seq, bdIf);
            modelPc = modelNpc(expPc, row, stimImm);
            // slot must hold while the PC is stalled
            if (row.stall) begin
                repeat (6) begin
                    @(negedge clk);
                    checkField("pcId", expPc, pcId);
                end
            end
            if (r == numRows - 1 || rows[r + 1].testNum != row.testNum) begin
                if (testErrors == 0) begin
                    testsOk++;
                    $display("test %0d ok", curTest);
                end else begin
                    testsBad++;
                    $display("test %0d had %0d mismatches", curTest, testErrors);
                end
                testErrors = 0;
            end
        end
        $display("%0d tests ok, %0d tests with errors", testsOk, testsBad);
        if (testsBad == 0 && !timedOut) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* fetchStage_asserts.sv */
module fetchStageAsserts (
    input logic        clk,
    input logic        reset,
    input logic        wbCyc,
    input logic        wbStb,
    input logic [31:0] wbAdr,
    input logic        wbAck
);
    timeunit 1ns;
    timeprecision 100ps;

    stbNeedsCyc: assert property (@(posedge clk) disable iff (reset) wbStb |-> wbCyc)
        else $error("wbStb high while wbCyc is low");

    // slave answers only a request seen on the previous edge
    ackFollowsStb: assert property (@(posedge clk) disable iff (reset) wbAck |-> $past(wbStb))
        else $error("wbAck without a preceding wbStb");

    adrStable: assert property (@(posedge clk) disable iff (reset)
        (wbStb && !wbAck) |=> $stable(wbAdr))
        else $error("wbAdr changed before wbAck");

    ackSingle: assert property (@(posedge clk) disable iff (reset) wbAck |=> !wbAck)
        else $error("wbAck high for two cycles in a row");

endmodule

bind fetchStage fetchStageAsserts i_fetchStageAsserts (
    .clk   (clk),
    .reset (reset),
    .wbCyc (wbCyc),
    .wbStb (wbStb),
    .wbAdr (wbAdr),
    .wbAck (wbAck)
);

/* ifIdReg.sv */
module ifIdReg import fetchPkg::*; (
    input  logic            clk,
    input  logic            reset,
    input  logic            clr,
    input  logic            load,
    input  logic [31:0]     code,
    input  logic [31:0]     pc,
    input  logic [excW-1:0] exc,
    input  logic            bd,
    output logic [31:0]     codeId,
    output logic [31:0]     pcId,
    output logic [excW-1:0] excId,
    output logic            bdId,
    output logic            validId
);

    // clr flushes the slot and beats a load on the same edge
    always_ff @(posedge clk) begin
        if (reset || clr) begin
            codeId <= '0;
            pcId <= '0;
            excId <= '0;
            bdId <= 1'b0;
            validId <= 1'b0;
        end else if (load) begin
            // word from memory, PC and exception from the PC unit
            codeId <= code;
            pcId <= pc;
            excId <= exc;
            bdId <= bd;
            validId <= 1'b1;
        end
    end

endmodule

/* instrMem.sv */
module instrMem import fetchPkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        wbCyc,
    input  logic        wbStb,
    input  logic [31:0] wbAdr,
    output logic        wbAck,
    output logic [31:0] wbDatRd
);

    logic [31:0]        mem [0:memWords-1];
    logic [memIdxW-1:0] wordIdx;
    logic               request;

    initial begin
        $readmemh("program.hex", mem);
    end

    // all other address bits are ignored
    assign wordIdx = wbAdr[memIdxW+1:2];

    // no back-to-back acks, so each request gets exactly one
    assign request = wbCyc && wbStb && !wbAck;

    always_ff @(posedge clk) begin
        if (reset) begin
            wbAck <= 1'b0;
        end else begin
            wbAck <= request;
        end
    end

    // read data lines up with the ack
    always_ff @(posedge clk) begin
        if (request) begin
            wbDatRd <= mem[wordIdx];
        end
    end

endmodule

/* nextPcUnit.sv */
module nextPcUnit import fetchPkg::*; (
    input  logic [31:0] pc,
    input  jumpKind_t   jumpKind,
    input  logic        cmp,
    input  logic [15:0] imm16,
    input  logic [25:0] jmpAddr,
    input  logic [31:0] jmpReg,
    input  kCtrl_t      kCtrl,
    input  logic [31:2] epc,
    output logic [31:0] npc,
    output logic        isJump
);

    logic [31:0] branchOffset;
    logic [31:0] branchTarget;
    logic [31:0] jumpTarget;
    logic [31:0] seqTarget;
    logic        atEnd;

    // word offset, sign extended and scaled to bytes
    assign branchOffset = {{14{imm16[15]}}, imm16, 2'b00};
    assign branchTarget = pc + branchOffset;

    // region bits come from the delay slot PC
    assign jumpTarget = {pc[31:28], jmpAddr, 2'b00};
    assign seqTarget = pc + 32'd4;

    // last word before the kernel vector ends the program
    assign atEnd = (pc == kTextStart - 32'd4);

    always_comb begin
        if (kCtrl == kEnter) begin
            npc = kTextStart;
        end else if (kCtrl == kEret) begin
            npc = {epc, 2'b00};
        end else if (atEnd) begin
            // hold here and keep fetching the same word
            npc = pc;
        end else begin
            case (jumpKind)
                branch: begin
                    if (cmp) begin
                        npc = branchTarget;
                    end else begin
                        npc = seqTarget;
                    end
                end
                jumpImm: begin
                    npc = jumpTarget;
                end
                jumpReg: begin
                    npc = jmpReg;
                end
                default: begin
                    npc = seqTarget;
                end
            endcase
        end
    end

    // any control transfer in decode puts the fetched word in a delay slot,
    // whether or not the branch is taken
    assign isJump = (jumpKind != seq);

endmodule

/* pcUnit.sv */
module pcUnit import fetchPkg::*; (
    input  logic            clk,
    input  logic            reset,
    input  logic            stall,
    input  logic [31:0]     npc,
    input  logic            wbAck,
    output logic [31:0]     pc,
    output logic [excW-1:0] exc,
    output logic            wbCyc,
    output logic            wbStb,
    output logic [31:0]     wbAdr
);

    logic [31:0] pcReg;
    logic        pending;
    logic        outOfRange;
    logic        misaligned;

    always_ff @(posedge clk) begin
        if (reset) begin
            pcReg <= textStart;
            pending <= 1'b0;
        end else begin
            // advance only when the current fetch is acknowledged
            if (pending && wbAck) begin
                pcReg <= npc;
            end
            // stall blocks only the start of a new cycle
            if (!pending || wbAck) begin
                pending <= !stall;
            end
        end
    end

    // address check on the PC being fetched
    assign outOfRange = (pcReg < textStart) || (pcReg >= textEnd);
    assign misaligned = (pcReg[1:0] != 2'b00);
    assign exc = (outOfRange || misaligned) ? excAdEl : '0;

    assign pc = pcReg;

    // bus request follows the pending flag, address is the PC itself
    assign wbCyc = pending;
    assign wbStb = pending;
    assign wbAdr = pcReg;

endmodule

/* program.hex */
// one 32-bit instruction word per line, word index 0 to 31 in order
A5000000
A5000004
A5000008
A500000C
A5000010
A5000014
A5000018
A500001C
A5000020
A5000024
A5000028
A500002C
A5000030
A5000034
A5000038
A500003C
A5000040
A5000044
A5000048
A500004C
A5000050
A5000054
A5000058
A500005C
A5000060
A5000064
A5000068
A500006C
A5000070
A5000074
A5000078
A500007C

/* sim.f */
fetchPkg.sv
nextPcUnit.sv
pcUnit.sv
instrMem.sv
ifIdReg.sv
fetchStage.sv
fetchStage_asserts.sv
fetchStageTb.sv
